/* files.f */
src/adc_scan_pkg.sv
src/adc_reg_file.sv
src/adc_channel_map.sv
src/adc_scan_fsm.sv
src/adc_scan_counters.sv
src/adc_sample_path.sv
src/adc_scan_ctrl.sv
sim/adc_model.sv
sim/tb_adc_scan.sv

/* sim/adc_model.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_model (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         start_i,
  input  wire  [4:0]  chnum_i,
  input  wire         hang_i,
  input  wire  [11:0] offset_i,
  output logic        busy_o,
  output logic        sample_o,
  output logic        datavalid_o,
  output logic [11:0] result_o
);

  logic [2:0] cnt;

  assign sample_o = busy_o; // track and hold during busy

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt         <= 3'd0;
      busy_o      <= 1'b0;
      datavalid_o <= 1'b0;
      result_o    <= 12'd0;
    end else begin
      datavalid_o <= 1'b0;
      if (hang_i) begin
        cnt    <= 3'd0; // dead converter, ignores start
        busy_o <= 1'b0;
      end else if (cnt == 3'd0) begin
        if (start_i)
          cnt <= 3'd1;
      end else begin
        cnt <= cnt + 3'd1;
        if (cnt == 3'd1)
          busy_o <= 1'b1;
        if (cnt == 3'd6) begin
          cnt         <= 3'd0;
          busy_o      <= 1'b0;
          datavalid_o <= 1'b1;
          result_o    <= 12'(chnum_i) * 12'd97 + offset_i; // wraps mod 4096
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_adc_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_adc_scan;

  localparam int settle_cycles = 12;
  localparam int model_lat     = 7;  // start to data-valid
  localparam int chan_cycles   = settle_cycles + model_lat + 6;
  localparam int scan_cycles   = 32 * chan_cycles;
  localparam int test_cycles   = 7 * scan_cycles + 800;
  localparam int watchdog_ns   = 2 * test_cycles * 40;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        cyc = 1'b0;
  logic        stb = 1'b0;
  logic        we = 1'b0;
  logic [15:0] adr = 16'd0;
  logic [15:0] dat_w = 16'd0;
  logic        calibrate = 1'b0;
  logic        hang = 1'b0;
  logic [11:0] offset = 12'd0;
  logic [15:0] dat_r;
  logic        ack;
  logic        start;
  logic [4:0]  chnum;
  logic        busy;
  logic        sample;
  logic        dv;
  logic [11:0] adc_res;
  logic [9:0]  cur_stb;
  logic [10:0] tmp_stb;
  logic [11:0] res;
  logic [4:0]  res_ch;
  logic        res_strb;

  int          errors = 0;
  int          strobe_total = 0;
  int          start_rises = 0;
  logic        start_prev = 1'b0;
  logic [4:0]  last_res_ch = 5'd0;
  int unsigned seed;
  logic [4:0]  res_ch_q[$];
  logic [11:0] res_val_q[$];

  always #20 clk = ~clk;

  adc_scan_ctrl #(.settle_cycles(settle_cycles)) dut0 (
    .wb_clk_i(clk), .wb_rst_i(rst), .wb_cyc_i(cyc), .wb_stb_i(stb), .wb_we_i(we),
    .wb_adr_i(adr), .wb_dat_i(dat_w), .wb_dat_o(dat_r), .wb_ack_o(ack),
    .adc_start_o(start), .adc_chnum_o(chnum), .adc_calibrate_i(calibrate),
    .adc_datavalid_i(dv), .adc_busy_i(busy), .adc_sample_i(sample),
    .adc_result_i(adc_res), .current_stb_o(cur_stb), .temp_stb_o(tmp_stb),
    .result_o(res), .result_channel_o(res_ch), .result_strb_o(res_strb)
  );

  adc_model adc0 (
    .clk_i(clk), .rst_i(rst), .start_i(start), .chnum_i(chnum), .hang_i(hang),
    .offset_i(offset), .busy_o(busy), .sample_o(sample), .datavalid_o(dv),
    .result_o(adc_res)
  );

  // result log and start edge counter
  always @(negedge clk) begin
    if (!rst) begin
      if (res_strb) begin
        res_ch_q.push_back(res_ch);
        res_val_q.push_back(res);
        last_res_ch = res_ch;
        strobe_total++;
      end
      if (start && !start_prev)
        start_rises++;
      start_prev = start;
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  function automatic int model_value(input int ch);
    return (ch * 97 + offset) % 4096;
  endfunction

  function automatic logic [9:0] cmon_select(input int ch, input logic [9:0] en);
    logic [9:0] m;
    m = '0;
    if (ch % 3 == 2 && ch <= 29)
      m[(ch - 2) / 3] = 1'b1;
    return m & en;
  endfunction

  function automatic logic [10:0] tmon_select(input int ch, input logic [10:0] en);
    logic [10:0] m;
    m = '0;
    if (ch == 31)
      m[10] = 1'b1;
    else if (ch % 3 == 0 && ch >= 3)
      m[ch / 3 - 1] = 1'b1;
    return m & en;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic flag_error(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic idle_for(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic bus_cycle(input logic wr, input logic [15:0] a, input logic [15:0] d,
                           output logic [15:0] q);
    int n;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < 16);
    if (!ack)
      flag_error("Wishbone cycle got no ack");
    q   = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic write_reg(input logic [15:0] a, input logic [15:0] d);
    logic [15:0] q;
    bus_cycle(1'b1, a, d, q);
  endtask

  task automatic read_reg(input logic [15:0] a, output logic [15:0] q);
    bus_cycle(1'b0, a, 16'd0, q);
  endtask

  task automatic write_readback(input string name, input logic [15:0] a, input logic [15:0] d);
    logic [15:0] q;
    write_reg(a, d);
    read_reg(a, q);
    check(name, d, q);
  endtask

  task automatic wait_results(input int n);
    int t;
    t = 0;
    while (res_ch_q.size() < n && t < 2 * scan_cycles) begin
      @(negedge clk);
      t++;
    end
    if (res_ch_q.size() < n)
      flag_error("timed out waiting for conversion results");
  endtask

  // leaves the log empty right after a result on channel ch
  task automatic sync_to_channel(input int ch);
    int   junk;
    logic found;
    res_ch_q.delete();
    res_val_q.delete();
    found = 1'b0;
    repeat (40) begin
      if (!found) begin
        wait_results(1);
        if (res_ch_q.size() > 0) begin
          found = (res_ch_q[0] == ch);
          junk  = res_ch_q.pop_front();
          junk  = res_val_q.pop_front();
        end
      end
    end
    if (!found)
      flag_error("scan never produced a result on the expected channel");
  endtask

  task automatic register_test();
    logic [15:0] q;
    read_reg(adc_scan_pkg::reg_bypass_lo, q);
    check("bypass_lo reset", 0, q);
    read_reg(adc_scan_pkg::reg_bypass_hi, q);
    check("bypass_hi reset", 0, q);
    read_reg(adc_scan_pkg::reg_cmon_en, q);
    check("cmon_en reset", adc_scan_pkg::cmon_rst, q);
    read_reg(adc_scan_pkg::reg_tmon_en, q);
    check("tmon_en reset", adc_scan_pkg::tmon_rst, q);
    read_reg(adc_scan_pkg::reg_adc_en, q);
    check("adc_en reset", adc_scan_pkg::adc_en_rst, q);
    write_readback("bypass_lo readback", adc_scan_pkg::reg_bypass_lo, 16'($urandom));
    write_readback("bypass_hi readback", adc_scan_pkg::reg_bypass_hi, 16'($urandom));
    write_readback("cmon_en readback", adc_scan_pkg::reg_cmon_en, 16'($urandom) & 16'h03ff);
    write_readback("tmon_en readback", adc_scan_pkg::reg_tmon_en, 16'($urandom) & 16'h07ff);
    write_readback("adc_en readback", adc_scan_pkg::reg_adc_en, 16'd0);
    write_reg(16'd6, 16'hbeef);
    read_reg(16'd6, q);
    check("unmapped 6", 0, q);
    read_reg(16'hffff, q);
    check("unmapped ffff", 0, q);
    write_reg(adc_scan_pkg::reg_bypass_lo, 16'd0);
    write_reg(adc_scan_pkg::reg_bypass_hi, 16'd0);
    write_reg(adc_scan_pkg::reg_adc_en, 16'd1);
  endtask

  task automatic bypass_scan_test();
    int exp_ch;
    write_reg(adc_scan_pkg::reg_cmon_en, 16'd0); // no settling, faster scan
    write_reg(adc_scan_pkg::reg_tmon_en, 16'd0);
    write_reg(adc_scan_pkg::reg_bypass_lo, 16'h0010);
    write_reg(adc_scan_pkg::reg_bypass_hi, 16'h0002);
    sync_to_channel(31);
    wait_results(30);
    exp_ch = 0;
    for (int i = 0; i < 30 && i < res_ch_q.size(); i++) begin
      if (exp_ch == 4 || exp_ch == 17)
        exp_ch++;
      check("scan channel", exp_ch, res_ch_q[i]);
      check("scan result", model_value(exp_ch), res_val_q[i]);
      exp_ch++;
    end
    write_reg(adc_scan_pkg::reg_bypass_lo, 16'd0);
    write_reg(adc_scan_pkg::reg_bypass_hi, 16'd0);
  endtask

  task automatic strobe_test();
    int   hi;
    int   c_starts;
    int   t_starts;
    int   t;
    logic prev;
    logic done;
    write_reg(adc_scan_pkg::reg_cmon_en, 16'h0008);
    write_reg(adc_scan_pkg::reg_tmon_en, 16'h0400);
    sync_to_channel(31);
    hi       = 0;
    c_starts = 0;
    t_starts = 0;
    t        = 0;
    done     = 1'b0;
    prev     = start;
    while (!done && t < 2 * scan_cycles) begin
      @(negedge clk);
      t++;
      if (cur_stb != 0 || tmp_stb != 0) begin
        check("current strobe", cmon_select(chnum, 10'h008), cur_stb);
        check("temp strobe", tmon_select(chnum, 11'h400), tmp_stb);
        if (!start)
          hi++;
        if (start && !prev) begin
          check("settle before start", 1, hi >= settle_cycles);
          if (cur_stb != 0)
            c_starts++;
          if (tmp_stb != 0)
            t_starts++;
        end
      end else begin
        hi = 0;
      end
      if (res_strb) begin
        check("strobes after result", 0, {cur_stb, tmp_stb});
        done = (res_ch == 31);
      end
      prev = start;
    end
    if (!done)
      flag_error("strobe scan did not reach channel 31");
    check("current strobe conversions", 1, c_starts);
    check("temp strobe conversions", 1, t_starts);
  endtask

  task automatic pause_test();
    int         s0;
    int         r0;
    logic [4:0] next_ch;
    write_reg(adc_scan_pkg::reg_adc_en, 16'd0);
    idle_for(2 * chan_cycles); // let the channel in flight finish
    next_ch = last_res_ch + 5'd1;
    s0 = strobe_total;
    r0 = start_rises;
    idle_for(200);
    check("results while disabled", s0, strobe_total);
    check("starts while disabled", r0, start_rises);
    @(negedge clk);
    calibrate = 1'b1;
    write_reg(adc_scan_pkg::reg_adc_en, 16'd1);
    idle_for(2 * chan_cycles);
    s0 = strobe_total;
    r0 = start_rises;
    idle_for(200);
    check("results while calibrating", s0, strobe_total);
    check("starts while calibrating", r0, start_rises);
    res_ch_q.delete();
    res_val_q.delete();
    @(negedge clk);
    calibrate = 1'b0;
    wait_results(1);
    if (res_ch_q.size() > 0)
      check("channel after calibrate", next_ch, res_ch_q[0]);
  endtask

  task automatic skip_test();
    logic [15:0] q;
    logic [4:0]  ch;
    logic [4:0]  nxt;
    int          s0;
    int          t;
    sync_to_channel(10); // channel 11 has its current monitor enabled
    @(negedge clk);
    hang = 1'b1;
    ch  = last_res_ch + 5'd1;
    nxt = ch + 5'd1;
    t = 0;
    q = 16'd0;
    while (q[6:4] != adc_scan_pkg::st_convert && q[6:4] != adc_scan_pkg::st_waiting
           && t < 4 * chan_cycles) begin
      read_reg(adc_scan_pkg::reg_status, q);
      t++;
    end
    if (q[6:4] != adc_scan_pkg::st_convert && q[6:4] != adc_scan_pkg::st_waiting)
      flag_error("scan did not stall on the hung ADC");
    check("stall channel", ch, chnum);
    check("strobe before skip", cmon_select(ch, 10'h008), cur_stb);
    s0  = strobe_total;
    write_reg(adc_scan_pkg::reg_status, 16'hffff);
    @(negedge clk);
    check("start after skip", 0, start);
    check("strobes after skip", 0, {cur_stb, tmp_stb});
    @(negedge clk);
    check("channel after skip", nxt, chnum);
    idle_for(20);
    check("results after skip", s0, strobe_total);
    hang = 1'b0;
  endtask

  task automatic count_test();
    logic [15:0] q;
    idle_for(2 * chan_cycles);
    write_reg(adc_scan_pkg::reg_adc_en, 16'd0);
    idle_for(2 * chan_cycles);
    read_reg(adc_scan_pkg::reg_status, q);
    check("result count", strobe_total % 256, q[14:7]);
    write_reg(adc_scan_pkg::reg_adc_en, 16'd1);
  endtask

  initial begin
    seed   = $urandom(32'h0276_8991);
    offset = $urandom % 4096;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    register_test();
    bypass_scan_test();
    strobe_test();
    pause_test();
    skip_test();
    count_test();
    $display("%0d errors, %0d results seen", errors, strobe_total);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/adc_channel_map.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_channel_map (
  input  wire  [adc_scan_pkg::chan_w-1:0]  chan_i,
  input  wire  [31:0]                      bypass_i,
  input  wire  [adc_scan_pkg::cmon_n-1:0]  cmon_en_i,
  input  wire  [adc_scan_pkg::tmon_n-1:0]  tmon_en_i,
  output logic                             bypassed_o,
  output logic                             need_strobe_o,
  output logic [adc_scan_pkg::cmon_n-1:0]  cmon_mask_o,
  output logic [adc_scan_pkg::tmon_n-1:0]  tmon_mask_o
);

  logic [adc_scan_pkg::cmon_n-1:0] cmon_sel;
  logic [adc_scan_pkg::tmon_n-1:0] tmon_sel;

  always_comb begin
    // current monitors sit on 2, 5, 8 .. 29
    for (int i = 0; i < adc_scan_pkg::cmon_n; i++)
      cmon_sel[i] = (int'(chan_i) == 3 * i + 2);
    // temperature monitors on 3, 6 .. 30
    for (int i = 0; i < adc_scan_pkg::tmon_n - 1; i++)
      tmon_sel[i] = (int'(chan_i) == 3 * i + 3);
    tmon_sel[adc_scan_pkg::tmon_n-1] = (chan_i == '1); // channel 31
  end

  assign cmon_mask_o   = cmon_sel & cmon_en_i;
  assign tmon_mask_o   = tmon_sel & tmon_en_i;
  assign need_strobe_o = (|cmon_mask_o) | (|tmon_mask_o);
  assign bypassed_o    = bypass_i[chan_i];

endmodule

`default_nettype wire

/* src/adc_reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_reg_file (
  input  wire                               wb_clk_i,
  input  wire                               wb_rst_i,
  input  wire                               wb_cyc_i,
  input  wire                               wb_stb_i,
  input  wire                               wb_we_i,
  input  wire  [15:0]                       wb_adr_i,
  input  wire  [15:0]                       wb_dat_i,
  output logic [15:0]                       wb_dat_o,
  output logic                              wb_ack_o,
  input  wire  [2:0]                        state_i,
  input  wire  [adc_scan_pkg::count_w-1:0]  result_count_i,
  input  wire                               adc_busy_i,
  input  wire                               adc_sample_i,
  input  wire                               adc_datavalid_i,
  input  wire                               adc_calibrate_i,
  output logic [31:0]                       bypass_o,
  output logic [adc_scan_pkg::cmon_n-1:0]   cmon_en_o,
  output logic [adc_scan_pkg::tmon_n-1:0]   tmon_en_o,
  output logic                              adc_en_o,
  output logic                              skip_o
);

  localparam logic [2:0] sel_zero = 3'd6; // unmapped address

  logic       cyc_go;
  logic [2:0] rd_sel;

  assign cyc_go = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o  <= 1'b0;
      skip_o    <= 1'b0;
      rd_sel    <= sel_zero;
      bypass_o  <= '0;
      cmon_en_o <= adc_scan_pkg::cmon_rst;
      tmon_en_o <= adc_scan_pkg::tmon_rst;
      adc_en_o  <= adc_scan_pkg::adc_en_rst;
    end else begin
      wb_ack_o <= cyc_go;
      skip_o   <= 1'b0;
      if (cyc_go) begin
        case (wb_adr_i)
          adc_scan_pkg::reg_bypass_lo: begin
            rd_sel <= 3'd0;
            if (wb_we_i)
              bypass_o[15:0] <= wb_dat_i;
          end
          adc_scan_pkg::reg_bypass_hi: begin
            rd_sel <= 3'd1;
            if (wb_we_i)
              bypass_o[31:16] <= wb_dat_i;
          end
          adc_scan_pkg::reg_cmon_en: begin
            rd_sel <= 3'd2;
            if (wb_we_i)
              cmon_en_o <= wb_dat_i[adc_scan_pkg::cmon_n-1:0];
          end
          adc_scan_pkg::reg_tmon_en: begin
            rd_sel <= 3'd3;
            if (wb_we_i)
              tmon_en_o <= wb_dat_i[adc_scan_pkg::tmon_n-1:0];
          end
          adc_scan_pkg::reg_adc_en: begin
            rd_sel <= 3'd4;
            if (wb_we_i)
              adc_en_o <= wb_dat_i[0];
          end
          adc_scan_pkg::reg_status: begin
            rd_sel <= 3'd5;
            skip_o <= wb_we_i; // data ignored
          end
          default: rd_sel <= sel_zero;
        endcase
      end
    end
  end

  // status fields are read live
  always_comb begin
    case (rd_sel)
      3'd0: wb_dat_o = bypass_o[15:0];
      3'd1: wb_dat_o = bypass_o[31:16];
      3'd2: wb_dat_o = {{(16 - adc_scan_pkg::cmon_n){1'b0}}, cmon_en_o};
      3'd3: wb_dat_o = {{(16 - adc_scan_pkg::tmon_n){1'b0}}, tmon_en_o};
      3'd4: wb_dat_o = {15'b0, adc_en_o};
      3'd5: wb_dat_o = {1'b0, result_count_i, state_i,
                        adc_busy_i, adc_sample_i, adc_datavalid_i, adc_calibrate_i};
      default: wb_dat_o = 16'd0;
    endcase
  end

endmodule

`default_nettype wire

/* src/adc_sample_path.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_sample_path (
  input  wire                                wb_clk_i,
  input  wire                                wb_rst_i,
  input  wire                                strobe_load_i,
  input  wire                                strobe_clear_i,
  input  wire                                capture_i,
  input  wire  [adc_scan_pkg::cmon_n-1:0]    cmon_mask_i,
  input  wire  [adc_scan_pkg::tmon_n-1:0]    tmon_mask_i,
  input  wire  [adc_scan_pkg::chan_w-1:0]    chan_i,
  input  wire  [adc_scan_pkg::result_w-1:0]  adc_result_i,
  output logic [adc_scan_pkg::cmon_n-1:0]    current_stb_o,
  output logic [adc_scan_pkg::tmon_n-1:0]    temp_stb_o,
  output logic [adc_scan_pkg::result_w-1:0]  result_o,
  output logic [adc_scan_pkg::chan_w-1:0]    result_channel_o,
  output logic                               result_strb_o
);

  // monitor excitation
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      current_stb_o <= '0;
      temp_stb_o    <= '0;
    end else if (strobe_clear_i) begin
      current_stb_o <= '0;
      temp_stb_o    <= '0;
    end else if (strobe_load_i) begin
      current_stb_o <= cmon_mask_i;
      temp_stb_o    <= tmon_mask_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (capture_i) begin
      result_o         <= adc_result_i;
      result_channel_o <= chan_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i)
      result_strb_o <= 1'b0;
    else
      result_strb_o <= capture_i; // one cycle per result
  end

endmodule

`default_nettype wire

/* src/adc_scan_counters.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_scan_counters #(
  parameter int settle_cycles = 400
) (
  input  wire                               wb_clk_i,
  input  wire                               wb_rst_i,
  input  wire                               load_settle_i,
  input  wire                               advance_i,
  input  wire                               capture_i,
  output logic                              settle_done_o,
  output logic [adc_scan_pkg::chan_w-1:0]   chan_o,
  output logic [adc_scan_pkg::count_w-1:0]  result_count_o
);

  localparam int settle_w = (settle_cycles > 1) ? $clog2(settle_cycles + 1) : 1;

  logic [settle_w-1:0] settle_cnt;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      settle_cnt     <= '0;
      chan_o         <= '0;
      result_count_o <= '0;
    end else begin
      // loaded value gives settle_cycles+1 clocks until start
      if (load_settle_i)
        settle_cnt <= settle_w'(settle_cycles);
      else if (settle_cnt != '0)
        settle_cnt <= settle_cnt - 1'b1;
      if (advance_i)
        chan_o <= chan_o + 1'b1; // wraps 31 -> 0
      if (capture_i)
        result_count_o <= result_count_o + 1'b1;
    end
  end

  assign settle_done_o = (settle_cnt == '0);

endmodule

`default_nettype wire

/* src/adc_scan_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_scan_ctrl #(
  parameter int settle_cycles = 400
) (
  input  wire                                wb_clk_i,
  input  wire                                wb_rst_i,
  input  wire                                wb_cyc_i,
  input  wire                                wb_stb_i,
  input  wire                                wb_we_i,
  input  wire  [15:0]                        wb_adr_i,
  input  wire  [15:0]                        wb_dat_i,
  output logic [15:0]                        wb_dat_o,
  output logic                               wb_ack_o,
  output logic                               adc_start_o,
  output logic [adc_scan_pkg::chan_w-1:0]    adc_chnum_o,
  input  wire                                adc_calibrate_i,
  input  wire                                adc_datavalid_i,
  input  wire                                adc_busy_i,
  input  wire                                adc_sample_i,
  input  wire  [adc_scan_pkg::result_w-1:0]  adc_result_i,
  output logic [adc_scan_pkg::cmon_n-1:0]    current_stb_o,
  output logic [adc_scan_pkg::tmon_n-1:0]    temp_stb_o,
  output logic [adc_scan_pkg::result_w-1:0]  result_o,
  output logic [adc_scan_pkg::chan_w-1:0]    result_channel_o,
  output logic                               result_strb_o
);

  logic [31:0]                       bypass;
  logic [adc_scan_pkg::cmon_n-1:0]   cmon_en;
  logic [adc_scan_pkg::tmon_n-1:0]   tmon_en;
  logic [adc_scan_pkg::cmon_n-1:0]   cmon_mask;
  logic [adc_scan_pkg::tmon_n-1:0]   tmon_mask;
  logic [adc_scan_pkg::chan_w-1:0]   chan;
  logic [adc_scan_pkg::count_w-1:0]  result_count;
  logic [2:0]                        state;
  logic adc_en, skip, bypassed, need_strobe, settle_done;
  logic load_settle, strobe_load, strobe_clear, capture, advance;

  assign adc_chnum_o = chan; // mux select follows the pointer

  adc_reg_file regs0 (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
    .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .state_i(state), .result_count_i(result_count),
    .adc_busy_i, .adc_sample_i, .adc_datavalid_i, .adc_calibrate_i,
    .bypass_o(bypass), .cmon_en_o(cmon_en), .tmon_en_o(tmon_en),
    .adc_en_o(adc_en), .skip_o(skip)
  );

  adc_channel_map map0 (
    .chan_i(chan), .bypass_i(bypass), .cmon_en_i(cmon_en), .tmon_en_i(tmon_en),
    .bypassed_o(bypassed), .need_strobe_o(need_strobe),
    .cmon_mask_o(cmon_mask), .tmon_mask_o(tmon_mask)
  );

  adc_scan_fsm fsm0 (
    .wb_clk_i, .wb_rst_i,
    .adc_en_i(adc_en), .skip_i(skip), .bypassed_i(bypassed),
    .need_strobe_i(need_strobe), .settle_done_i(settle_done),
    .adc_calibrate_i, .adc_busy_i, .adc_datavalid_i,
    .adc_start_o, .load_settle_o(load_settle), .strobe_load_o(strobe_load),
    .strobe_clear_o(strobe_clear), .capture_o(capture), .advance_o(advance),
    .state_o(state)
  );

  adc_scan_counters #(.settle_cycles(settle_cycles)) cnt0 (
    .wb_clk_i, .wb_rst_i,
    .load_settle_i(load_settle), .advance_i(advance), .capture_i(capture),
    .settle_done_o(settle_done), .chan_o(chan), .result_count_o(result_count)
  );

  adc_sample_path path0 (
    .wb_clk_i, .wb_rst_i,
    .strobe_load_i(strobe_load), .strobe_clear_i(strobe_clear), .capture_i(capture),
    .cmon_mask_i(cmon_mask), .tmon_mask_i(tmon_mask), .chan_i(chan),
    .adc_result_i, .current_stb_o, .temp_stb_o,
    .result_o, .result_channel_o, .result_strb_o
  );

endmodule

`default_nettype wire

/* src/adc_scan_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_scan_fsm (
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  input  wire         adc_en_i,
  input  wire         skip_i,
  input  wire         bypassed_i,
  input  wire         need_strobe_i,
  input  wire         settle_done_i,
  input  wire         adc_calibrate_i,
  input  wire         adc_busy_i,
  input  wire         adc_datavalid_i,
  output logic        adc_start_o,
  output logic        load_settle_o,
  output logic        strobe_load_o,
  output logic        strobe_clear_o,
  output logic        capture_o,
  output logic        advance_o,
  output logic [2:0]  state_o
);

  logic [2:0] state;
  logic [2:0] state_nxt;
  logic       start_nxt;

  always_comb begin
    state_nxt      = state;
    start_nxt      = adc_start_o;
    load_settle_o  = 1'b0;
    strobe_load_o  = 1'b0;
    strobe_clear_o = 1'b0;
    capture_o      = 1'b0;
    advance_o      = 1'b0;
    case (state)
      adc_scan_pkg::st_idle: begin
        if (adc_en_i && !adc_calibrate_i) begin
          if (bypassed_i) begin
            state_nxt = adc_scan_pkg::st_done;
          end else if (need_strobe_i) begin
            state_nxt     = adc_scan_pkg::st_strobe;
            load_settle_o = 1'b1;
            strobe_load_o = 1'b1; // strobes rise with the state change
          end else begin
            state_nxt = adc_scan_pkg::st_convert;
            start_nxt = 1'b1;
          end
        end
      end
      adc_scan_pkg::st_strobe: begin
        if (settle_done_i) begin
          state_nxt = adc_scan_pkg::st_convert;
          start_nxt = 1'b1;
        end
      end
      adc_scan_pkg::st_convert: begin
        if (adc_busy_i || adc_datavalid_i) begin
          state_nxt = adc_scan_pkg::st_waiting;
          start_nxt = 1'b0;
        end else if (skip_i) begin
          state_nxt      = adc_scan_pkg::st_done;
          start_nxt      = 1'b0;
          strobe_clear_o = 1'b1;
        end
      end
      adc_scan_pkg::st_waiting: begin
        if (adc_datavalid_i) begin
          state_nxt      = adc_scan_pkg::st_done;
          capture_o      = 1'b1;
          strobe_clear_o = 1'b1;
        end else if (skip_i) begin // hung conversion
          state_nxt      = adc_scan_pkg::st_done;
          start_nxt      = 1'b0;
          strobe_clear_o = 1'b1;
        end
      end
      adc_scan_pkg::st_done: begin
        state_nxt = adc_scan_pkg::st_idle;
        advance_o = 1'b1;
      end
      default: begin
        state_nxt = adc_scan_pkg::st_idle;
        start_nxt = 1'b0;
      end
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state       <= adc_scan_pkg::st_idle;
      adc_start_o <= 1'b0;
    end else begin
      state       <= state_nxt;
      adc_start_o <= start_nxt;
    end
  end

  assign state_o = state;

endmodule

`default_nettype wire

/* src/adc_scan_pkg.sv */
`default_nettype none

package adc_scan_pkg;

  // wishbone register map
  localparam logic [15:0] reg_bypass_lo = 16'd0;
  localparam logic [15:0] reg_bypass_hi = 16'd1;
  localparam logic [15:0] reg_cmon_en   = 16'd2;
  localparam logic [15:0] reg_tmon_en   = 16'd3;
  localparam logic [15:0] reg_adc_en    = 16'd4;
  localparam logic [15:0] reg_status    = 16'd5;

  localparam int chan_w   = 5;
  localparam int result_w = 12;
  localparam int cmon_n   = 10;
  localparam int tmon_n   = 11;
  localparam int count_w  = 8;

  // scan states, visible in the status word
  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_strobe  = 3'd1;
  localparam logic [2:0] st_convert = 3'd2;
  localparam logic [2:0] st_waiting = 3'd3;
  localparam logic [2:0] st_done    = 3'd4;

  localparam logic [cmon_n-1:0] cmon_rst   = '1; // all monitors on
  localparam logic [tmon_n-1:0] tmon_rst   = '1;
  localparam logic              adc_en_rst = 1'b1;

endpackage

`default_nettype wire
